/* verilog/cache_geom_pkg.sv */
package cache_geom_pkg;

   // byte address of the processor port
   localparam int addr_width = 16;

   // address split: tag | index | byte in line
   localparam int offset_width = 4;
   localparam int index_width = 5;
   localparam int tag_width = addr_width - index_width - offset_width;

   // line geometry
   localparam int line_bytes = 1 << offset_width;
   localparam int line_width = line_bytes * 8;
   localparam int num_lines = 1 << index_width;

   // one write enable per byte lane of a line
   typedef logic [line_bytes-1:0] byte_mask_t;

   // field view of an address
   // msb first, so tag sits in [15:9] and offset in [3:0]
   typedef struct packed
   {
      logic [tag_width-1:0]    tag;
      logic [index_width-1:0]  index;
      logic [offset_width-1:0] offset;
   } addr_fields_t;

   // one address word, seen raw or split into fields
   typedef union packed
   {
      logic [addr_width-1:0] raw;
      addr_fields_t          f;
   } cache_addr_u;

endpackage

/* verilog/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

   // one-hot controller state
   typedef logic [8:0] state_t;

   // bit positions of the one-hot states
   localparam int st_idle = 0;
   localparam int st_rd = 1;
   localparam int st_rd_hit = 2;
   localparam int st_rd_miss = 3;
   localparam int st_rd_evict = 4;
   localparam int st_wr = 5;
   localparam int st_wr_hit = 6;
   localparam int st_wr_miss = 7;
   localparam int st_wr_evict = 8;

   // full code of the idle state
   localparam state_t idle_state = state_t'(1) << st_idle;

   // processor request, held until ready
   // size: bit0 = 1 byte, bit1 = 2, bit2 = 4, bit3 = 8, zero = whole line
   typedef struct packed
   {
      logic                                    enable;
      logic                                    rw;
      logic [cache_geom_pkg::addr_width-1:0]   addr;
      logic [3:0]                              size;
      logic [cache_geom_pkg::line_width-1:0]   wdata;
   } cpu_req_t;

   // line-wide memory bus, wr high for a write-back
   typedef struct packed
   {
      logic                                    en;
      logic                                    wr;
      logic [cache_geom_pkg::addr_width-1:0]   addr;
      logic [cache_geom_pkg::line_width-1:0]   wdata;
   } bus_req_t;

   // control word decoded from the state
   typedef struct packed
   {
      logic fill;
      logic cpu_write;
      logic tag_write;
      logic write_back;
      logic bus_en;
      logic ready;
   } ctrl_t;

endpackage

/* verilog/cache_fsm.sv */
`timescale 1ns/100ps

module cache_fsm
(
   input  logic                  CLK,
   input  logic                  reset,
   input  logic                  enable,
   input  logic                  rw,
   input  logic                  hit,
   input  logic                  evict,
   input  logic                  bus_r,
   output cache_ctrl_pkg::ctrl_t ctrl
);

   import cache_ctrl_pkg::*;

   state_t state;
   state_t next_state;

   // one term per incoming arc of each state
   always_comb
   begin
      next_state = '0;
      // idle holds until a request, hit states always return
      next_state[st_idle] = (state[st_idle] && !enable)
                            || state[st_rd_hit] || state[st_wr_hit];
      // request decode
      next_state[st_rd] = state[st_idle] && enable && !rw;
      next_state[st_wr] = state[st_idle] && enable && rw;
      // read side
      next_state[st_rd_hit] = (state[st_rd] && hit)
                              || (state[st_rd_miss] && bus_r);
      next_state[st_rd_miss] = (state[st_rd] && !hit && !evict)
                               || (state[st_rd_evict] && bus_r)
                               || (state[st_rd_miss] && !bus_r);
      next_state[st_rd_evict] = (state[st_rd] && !hit && evict)
                                || (state[st_rd_evict] && !bus_r);
      // write side, same shape
      next_state[st_wr_hit] = (state[st_wr] && hit)
                              || (state[st_wr_miss] && bus_r);
      next_state[st_wr_miss] = (state[st_wr] && !hit && !evict)
                               || (state[st_wr_evict] && bus_r)
                               || (state[st_wr_miss] && !bus_r);
      next_state[st_wr_evict] = (state[st_wr] && !hit && evict)
                                || (state[st_wr_evict] && !bus_r);
      // a broken code falls back to idle
      if (!$onehot(next_state))
      begin
         next_state = idle_state;
      end
   end

   // state step
   always_ff @(posedge CLK)
   begin
      if (reset)
      begin
         state <= idle_state;
      end
      else
      begin
         state <= next_state;
      end
   end

   // control decode, pure function of the state
   always_comb
   begin
      // line comes from the bus in the miss states
      ctrl.fill = state[st_rd_miss] || state[st_wr_miss];
      // processor bytes merged in only on a write hit
      ctrl.cpu_write = state[st_wr_hit];
      // tag and valid updated on every completion
      ctrl.tag_write = state[st_rd_hit] || state[st_wr_hit];
      // victim line out in the evict states
      ctrl.write_back = state[st_rd_evict] || state[st_wr_evict];
      // bus busy in miss and evict
      ctrl.bus_en = state[st_rd_miss] || state[st_wr_miss]
                    || state[st_rd_evict] || state[st_wr_evict];
      // one-cycle done pulse
      ctrl.ready = state[st_rd_hit] || state[st_wr_hit];
   end

endmodule

/* verilog/tag_store.sv */
`timescale 1ns/100ps

module tag_store
(
   input  logic                                 CLK,
   input  logic                                 reset,
   input  logic [cache_geom_pkg::index_width-1:0] index,
   input  logic [cache_geom_pkg::tag_width-1:0]   tag,
   input  logic                                 tag_write,
   output logic                                 hit,
   output logic                                 evict,
   output logic [cache_geom_pkg::tag_width-1:0]   victim_tag
);

   import cache_geom_pkg::*;

   // tag per line
   logic [tag_width-1:0] tags [num_lines];
   // valid per line, kept apart so reset can clear it
   logic [num_lines-1:0] valid;
   logic                 line_valid;
   logic                 tag_match;

   // valid bits
   always_ff @(posedge CLK)
   begin
      if (reset)
      begin
         valid <= '0;
      end
      else if (tag_write)
      begin
         valid[index] <= 1'b1;
      end
   end

   // tag array
   always_ff @(posedge CLK)
   begin
      if (tag_write)
      begin
         tags[index] <= tag;
      end
   end

   // combinational lookup of the indexed line
   assign victim_tag = tags[index];
   assign line_valid = valid[index];
   assign tag_match = (victim_tag == tag);

   // valid and same tag
   assign hit = line_valid && tag_match;
   // valid but another tag, old line must go out first
   assign evict = line_valid && !tag_match;

endmodule

/* verilog/line_store.sv */
`timescale 1ns/100ps

module line_store
(
   input  logic                                   CLK,
   input  logic [cache_geom_pkg::index_width-1:0]  index,
   input  logic [cache_geom_pkg::offset_width-1:0] offset,
   input  logic [3:0]                             size,
   input  logic                                   fill,
   input  logic                                   cpu_write,
   input  logic [cache_geom_pkg::line_width-1:0]   cpu_wdata,
   input  logic [cache_geom_pkg::line_width-1:0]   fill_data,
   input  logic                                   bus_r,
   output logic [cache_geom_pkg::line_width-1:0]   line_out,
   output logic [cache_geom_pkg::line_width-1:0]   rdata
);

   import cache_geom_pkg::*;

   // data array
   logic [line_width-1:0] lines [num_lines];

   byte_mask_t            size_mask;
   byte_mask_t            byte_mask;
   logic [line_width-1:0] shifted_wdata;
   logic [6:0]            bit_shift;

   // byte offset as a bit count
   assign bit_shift = {offset, 3'b000};

   // lanes covered by the access size, from byte 0
   // 0001, 0003, 000f, 00ff or ffff
   always_comb
   begin
      size_mask = '0;
      size_mask[0] = 1'b1;
      size_mask[1] = |size[3:1];
      size_mask[3:2] = {2{|size[3:2]}};
      size_mask[7:4] = {4{size[3]}};
      // no size bit means the whole line
      if (size == 4'b0000)
      begin
         size_mask = '1;
      end
   end

   // move mask and data up to the offset
   // lanes pushed past byte 15 fall off the top
   assign byte_mask = size_mask << offset;
   assign shifted_wdata = cpu_wdata << bit_shift;

   // fill has priority, whole line at the bus_r edge
   always_ff @(posedge CLK)
   begin
      if (fill && bus_r)
      begin
         lines[index] <= fill_data;
      end
      else if (cpu_write)
      begin
         for (int b = 0; b < line_bytes; b++)
         begin
            if (byte_mask[b])
            begin
               lines[index][8*b +: 8] <= shifted_wdata[8*b +: 8];
            end
         end
      end
   end

   // raw line for write-back
   assign line_out = lines[index];
   // aligned to byte 0 for the processor
   assign rdata = line_out >> bit_shift;

endmodule

/* verilog/cache.sv */
`timescale 1ns/100ps

module cache
(
   input  logic                                 CLK,
   input  logic                                 reset,
   input  cache_ctrl_pkg::cpu_req_t             req,
   output logic [cache_geom_pkg::line_width-1:0] rdata,
   output logic                                 ready,
   output cache_ctrl_pkg::bus_req_t             bus,
   input  logic                                 bus_r,
   input  logic [cache_geom_pkg::line_width-1:0] bus_rdata
);

   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   ctrl_t                 ctrl;
   cache_addr_u           addr_q;
   cache_addr_u           bus_addr;
   logic                  busy;
   logic                  hit;
   logic                  evict;
   logic [tag_width-1:0]  victim_tag;
   logic [line_width-1:0] line_out;

   // mirrors the controller leaving idle
   // set when a request is taken, cleared with ready
   always_ff @(posedge CLK)
   begin
      if (reset)
      begin
         busy <= 1'b0;
      end
      else if (ctrl.ready)
      begin
         busy <= 1'b0;
      end
      else if (req.enable)
      begin
         busy <= 1'b1;
      end
   end

   // address latch, open only while idle
   always_ff @(posedge CLK)
   begin
      if (!busy)
      begin
         addr_q.raw <= req.addr;
      end
   end

   // line address for the bus
   // write-back goes to where the victim came from
   always_comb
   begin
      bus_addr = addr_q;
      bus_addr.f.offset = '0;
      if (ctrl.write_back)
      begin
         bus_addr.f.tag = victim_tag;
      end
   end

   assign bus.en = ctrl.bus_en;
   assign bus.wr = ctrl.write_back;
   assign bus.addr = bus_addr.raw;
   assign bus.wdata = line_out;
   assign ready = ctrl.ready;

   cache_fsm fsm_i
   (
      .CLK    (CLK),
      .reset  (reset),
      .enable (req.enable),
      .rw     (req.rw),
      .hit    (hit),
      .evict  (evict),
      .bus_r  (bus_r),
      .ctrl   (ctrl)
   );

   tag_store tags_i
   (
      .CLK        (CLK),
      .reset      (reset),
      .index      (addr_q.f.index),
      .tag        (addr_q.f.tag),
      .tag_write  (ctrl.tag_write),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag)
   );

   line_store lines_i
   (
      .CLK       (CLK),
      .index     (addr_q.f.index),
      .offset    (addr_q.f.offset),
      .size      (req.size),
      .fill      (ctrl.fill),
      .cpu_write (ctrl.cpu_write),
      .cpu_wdata (req.wdata),
      .fill_data (bus_rdata),
      .bus_r     (bus_r),
      .line_out  (line_out),
      .rdata     (rdata)
   );

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb;

   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   logic                  CLK;
   logic                  reset;
   cpu_req_t              req;
   logic [line_width-1:0] rdata;
   logic                  ready;
   bus_req_t              bus;
   logic                  bus_r;
   logic [line_width-1:0] bus_rdata;

   int                    errors;
   int                    checks;
   logic                  timed_out;

   // bus memory with one entry per line address
   logic [line_width-1:0] mem [logic [addr_width-1:0]];
   // write-backs announced by the stimulus in order
   logic [addr_width-1:0] wb_addr_q [$];
   logic [line_width-1:0] wb_data_q [$];
   logic [addr_width-1:0] cur_addr;
   logic [31:0]           rnd_state;
   logic                  bus_active;
   int                    bus_wait;
   int                    bus_count;

   // stimulus file fields
   int                    fd;
   int                    n;
   string                 line;
   logic [7:0]            acc_op;
   logic [addr_width-1:0] acc_addr;
   logic [3:0]            acc_size;
   int                    acc_nbus;
   logic [line_width-1:0] acc_wdata;
   logic [line_width-1:0] acc_exp;

   cache cache_i
   (
      .CLK       (CLK),
      .reset     (reset),
      .req       (req),
      .rdata     (rdata),
      .ready     (ready),
      .bus       (bus),
      .bus_r     (bus_r),
      .bus_rdata (bus_rdata)
   );

   // 40 ns period
   initial
   begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] v);
      logic [31:0] x;
      x = v;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // contents of a line never written derive from its line address
   function automatic logic [line_width-1:0] fill_pattern(input logic [addr_width-1:0] a);
      logic [31:0] x;
      x = xorshift({16'h0000, a});
      return {x ^ 32'h33333333, x ^ 32'h22222222, x ^ 32'h11111111, x};
   endfunction

   function automatic logic [line_width-1:0] fetch_line(input logic [addr_width-1:0] a);
      if (mem.exists(a))
         return mem[a];
      return fill_pattern(a);
   endfunction

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // bus phase seen for the first time
   task automatic start_transfer();
      bus_active = 1'b1;
      bus_count++;
      rnd_state = xorshift(rnd_state);
      // answer after 1 to 4 cycles
      bus_wait = int'(rnd_state[1:0]);
      if (bus.wr)
      begin
         if (wb_addr_q.size() == 0)
         begin
            $display("write-back to %h that no access expects", bus.addr);
            errors++;
         end
         else
         begin
            check("bus.addr", 128'(bus.addr), 128'(wb_addr_q[0]));
            check("bus.wdata", bus.wdata, wb_data_q[0]);
            if (bus.addr == wb_addr_q[0] && bus.wdata == wb_data_q[0])
               $display("write-back of line %h matches", bus.addr);
            void'(wb_addr_q.pop_front());
            void'(wb_data_q.pop_front());
         end
         mem[bus.addr] = bus.wdata;
      end
      else
         // fetch names the line with the offset zeroed
         check("bus.addr", 128'(bus.addr), 128'({cur_addr[15:4], 4'h0}));
   endtask

   // memory model driving its inputs on the falling edge
   initial
   begin
      bus_r = 1'b0;
      bus_rdata = '0;
      bus_active = 1'b0;
      bus_wait = 0;
      bus_count = 0;
      rnd_state = 32'h7d74;
      forever
      begin
         @(negedge CLK);
         if (bus_r)
         begin
            // taken at the last rising edge
            bus_r = 1'b0;
            bus_active = 1'b0;
         end
         else if (bus_active)
         begin
            // request must stay up while the bus stalls
            check("bus.en", 128'(bus.en), 128'(1));
            if (bus_wait == 0)
            begin
               if (!bus.wr)
                  bus_rdata = fetch_line(bus.addr);
               bus_r = 1'b1;
            end
            else
               bus_wait--;
         end
         else if (bus.en)
            start_transfer();
      end
   end

   // one processor access held until ready
   task automatic run_op(input logic [7:0] op, input logic [addr_width-1:0] addr,
                         input logic [3:0] size, input int nbus,
                         input logic [line_width-1:0] wdata,
                         input logic [line_width-1:0] exp);
      int                    cycles;
      int                    start_count;
      logic [line_width-1:0] got;
      @(negedge CLK);
      cur_addr = addr;
      start_count = bus_count;
      req.enable = 1'b1;
      req.rw = (op == "w");
      req.addr = addr;
      req.size = size;
      req.wdata = wdata;
      cycles = 0;
      // one count per rising edge
      while (!ready && cycles < 200)
      begin
         @(negedge CLK);
         cycles++;
      end
      if (!ready)
      begin
         $display("no ready within %0d cycles for the access to %h", cycles, addr);
         errors++;
         timed_out = 1'b1;
      end
      else
      begin
         got = rdata;
         // write merges at the edge that ends the ready cycle
         @(negedge CLK);
         req.enable = 1'b0;
         // ready lasts a single cycle
         check("ready", 128'(ready), 128'(0));
         check("bus transfers", 128'(bus_count - start_count), 128'(nbus));
         // hit answers two edges after enable is taken
         if (nbus == 0)
            check("ready latency", 128'(cycles), 128'(2));
         if (op == "r")
            check("rdata", got, exp);
         check("pending write-backs", 128'(wb_addr_q.size()), 128'(0));
      end
   endtask

   initial
   begin
      errors = 0;
      checks = 0;
      timed_out = 1'b0;
      cur_addr = '0;
      reset = 1'b1;
      req = '0;
      repeat (16) @(posedge CLK);
      @(negedge CLK);
      reset = 1'b0;
      // idle outputs without a request
      repeat (4)
      begin
         @(negedge CLK);
         check("ready", 128'(ready), 128'(0));
         check("bus.en", 128'(bus.en), 128'(0));
         check("bus.wr", 128'(bus.wr), 128'(0));
      end
      fd = $fopen("verification/cache_stim.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the stimulus file");
         errors++;
      end
      else
      begin
         while (!$feof(fd) && !timed_out)
         begin
            line = "";
            n = $fgets(line, fd);
            // skip comments and blank lines
            if (n > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%c %h %h %d %h %h", acc_op, acc_addr, acc_size,
                           acc_nbus, acc_wdata, acc_exp);
               if (n != 6)
               begin
                  $display("stimulus line does not hold six fields: %s", line);
                  errors++;
               end
               else if (acc_op == "v")
               begin
                  wb_addr_q.push_back(acc_addr);
                  wb_data_q.push_back(acc_exp);
               end
               else
                  run_op(acc_op, acc_addr, acc_size, acc_nbus, acc_wdata, acc_exp);
            end
         end
         $fclose(fd);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* verification/cache_stim.txt */
# op addr size bus_transfers wdata expected (hex, size 0 = whole line)
# op r = read with expected rdata, w = write, v = next access writes back line addr with data
r 1235 0 1 00000000000000000000000000000000 000000000079B7424068A653515B9560
r 1235 0 0 00000000000000000000000000000000 000000000079B7424068A653515B9560
r 1230 0 0 00000000000000000000000000000000 79B7424068A653515B9560624A847173
w 1231 1 0 999999999999999999999999999999EE 00000000000000000000000000000000
w 1236 2 0 8888888888888888888888888888BBAA 00000000000000000000000000000000
w 1238 4 0 77777777777777777777777744332211 00000000000000000000000000000000
w 123C 8 0 66666666666666668877665544332211 00000000000000000000000000000000
r 1230 0 0 00000000000000000000000000000000 4433221144332211BBAA60624A84EE73
r 1233 0 0 00000000000000000000000000000000 0000004433221144332211BBAA60624A
v 1230 0 0 00000000000000000000000000000000 4433221144332211BBAA60624A84EE73
w 3230 0 2 C0C1C2C3C4C5C6C7C8C9CACBCCCDCECF 00000000000000000000000000000000
r 3237 0 0 00000000000000000000000000000000 00000000000000C0C1C2C3C4C5C6C7C8
v 3230 0 0 00000000000000000000000000000000 C0C1C2C3C4C5C6C7C8C9CACBCCCDCECF
w 123A 1 2 0000000000000000000000000000005A 00000000000000000000000000000000
r 1230 0 0 00000000000000000000000000000000 44332211445A2211BBAA60624A84EE73
w 1232 0 0 0F0E0D0C0B0A09080706050403020100 00000000000000000000000000000000
r 123F 0 0 00000000000000000000000000000000 0000000000000000000000000000000D
r 1230 0 0 00000000000000000000000000000000 0D0C0B0A09080706050403020100EE73
v 1230 0 0 00000000000000000000000000000000 0D0C0B0A09080706050403020100EE73
r 3230 0 2 00000000000000000000000000000000 C0C1C2C3C4C5C6C7C8C9CACBCCCDCECF

/* sources.f */
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/cache_fsm.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/cache.sv
verification/cache_tb.sv

/* Makefile */
# Verilator flow for the cache testbench
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
